//--- tb.f
+incdir+source
source/per2axi_pkg.sv
source/per2axi_buffer.sv
source/per2axi_req_channel.sv
source/per2axi_res_channel.sv
source/per2axi.sv
tests/axi_mem_model.sv
tests/tb_per2axi.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_per2axi
FILELIST  ?= tb.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

//--- tests/tb_per2axi.sv
`timescale 1ns/10ps
`default_nettype none

`include "per2axi_defs.svh"

module tb_per2axi;

   localparam logic [2:0] EXP_SIZE = 3'($clog2(`PER2AXI_DATA_WIDTH / 8));

   logic clk, rst_n, hold;
   logic per_req_valid, per_gnt, per_rsp_valid;
   per2axi_pkg::per_req_t per_req;
   per2axi_pkg::per_rsp_t per_rsp;
   logic aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready;
   logic b_valid, b_ready, r_valid, r_ready;
   per2axi_pkg::aw_t aw;
   per2axi_pkg::w_t  w;
   per2axi_pkg::ar_t ar;
   per2axi_pkg::b_t  b;
   per2axi_pkg::r_t  r;

   logic [31:0] ref_mem [256];
   logic [31:0] addr_q[$];
   logic [3:0]  be_q[$];
   int errors, test_start;
   int payload_errors;  // AW and W payload checks, active for the whole run.
   bit aborted;

   per2axi UUT (
      .clk_i(clk), .rst_n_i(rst_n),
      .per_req_valid_i(per_req_valid), .per_req_i(per_req), .per_gnt_o(per_gnt),
      .per_rsp_valid_o(per_rsp_valid), .per_rsp_o(per_rsp),
      .aw_valid_o(aw_valid), .aw_o(aw), .aw_ready_i(aw_ready),
      .w_valid_o(w_valid), .w_o(w), .w_ready_i(w_ready),
      .ar_valid_o(ar_valid), .ar_o(ar), .ar_ready_i(ar_ready),
      .b_valid_i(b_valid), .b_i(b), .b_ready_o(b_ready),
      .r_valid_i(r_valid), .r_i(r), .r_ready_o(r_ready)
   );

   axi_mem_model slave_i (
      .clk_i(clk), .rst_n_i(rst_n), .hold_aw_w_i(hold),
      .aw_valid_i(aw_valid), .aw_i(aw), .aw_ready_o(aw_ready),
      .w_valid_i(w_valid), .w_i(w), .w_ready_o(w_ready),
      .ar_valid_i(ar_valid), .ar_i(ar), .ar_ready_o(ar_ready),
      .b_valid_o(b_valid), .b_o(b), .b_ready_i(b_ready),
      .r_valid_o(r_valid), .r_o(r), .r_ready_i(r_ready)
   );

   always #20 clk = !clk;

   assert property (@(posedge clk) disable iff (!rst_n)
      aw_valid |-> (aw.len == 8'd0 && aw.burst == 2'b01 && aw.size == EXP_SIZE))
   else begin
      $display("[FAIL] %0t aw_o len/burst/size got %0d/%0d/%0d expected 0/1/%0d",
               $time, aw.len, aw.burst, aw.size, EXP_SIZE);
      payload_errors++;
   end
   assert property (@(posedge clk) disable iff (!rst_n) w_valid |-> w.last)
   else begin
      $display("[FAIL] %0t w_o.last got 0 expected 1", $time);
      payload_errors++;
   end
   assert property (@(posedge clk) disable iff (!rst_n)
      (aw_valid && !aw_ready) |=> (aw_valid && $stable(aw)))
   else begin
      $display("AW payload changed or dropped before its handshake at %0t", $time);
      payload_errors++;
   end
   assert property (@(posedge clk) disable iff (!rst_n)
      (w_valid && !w_ready) |=> (w_valid && $stable(w)))
   else begin
      $display("W payload changed or dropped before its handshake at %0t", $time);
      payload_errors++;
   end
   assert property (@(posedge clk) disable iff (!rst_n)
      (ar_valid && !ar_ready) |=> (ar_valid && $stable(ar)))
   else begin
      $display("AR payload changed or dropped before its handshake at %0t", $time);
      errors++;
   end
   assert property (@(posedge clk) disable iff (!rst_n) per_rsp_valid |=> !per_rsp_valid)
   else begin
      $display("Response valid lasted more than one cycle at %0t", $time);
      errors++;
   end
   assert property (@(posedge clk) disable iff (!rst_n) r_ready && !(r_valid && b_ready))
   else begin
      $display("R ready low or B ready high during a valid R at %0t", $time);
      errors++;
   end

   // Granted write addresses and byte enables against the AW and W handshakes.
   always @(posedge clk) begin
      if (rst_n && per_gnt && per_req_valid && per_req.we) begin
         addr_q.push_back({per_req.addr[31:2], 2'b00});
         be_q.push_back(per_req.be);
      end
      if (rst_n && aw_valid && aw_ready) begin
         assert (addr_q.size() > 0 && aw.addr == addr_q[0])
         else begin
            $display("[FAIL] %0t aw_o.addr got %h expected %h", $time, aw.addr, addr_q[0]);
            payload_errors++;
         end
         if (addr_q.size() > 0) void'(addr_q.pop_front());
      end
      if (rst_n && w_valid && w_ready) begin
         assert (be_q.size() > 0 && w.strb == be_q[0])
         else begin
            $display("[FAIL] %0t w_o.strb got %h expected %h", $time, w.strb, be_q[0]);
            payload_errors++;
         end
         if (be_q.size() > 0) void'(be_q.pop_front());
      end
   end

   task automatic issue(input logic [31:0] addr, input logic we, input logic [31:0] data,
                        input logic [3:0] be, input logic [3:0] id, input int max_cycles,
                        output bit granted);
      granted = 1'b0;
      @(posedge clk);
      #2;
      per_req_valid = 1'b1;
      per_req = '{addr: addr, we: we, wdata: data, be: be, id: id};
      for (int n = 0; n < max_cycles; n++) begin
         @(negedge clk);
         if (per_gnt) begin
            granted = 1'b1;
            break;
         end
         @(posedge clk);
         #2;
      end
      if (granted) begin
         @(posedge clk);
         #2;
         if (we && !addr[31]) begin
            for (int k = 0; k < 4; k++) begin
               if (be[k]) ref_mem[addr[9:2]][8*k +: 8] = data[8*k +: 8];
            end
         end
      end
      per_req_valid = 1'b0;
   endtask

   task automatic wait_rsp(input logic [3:0] id, input logic opc, input logic [31:0] data);
      bit found;
      found = 1'b0;
      for (int n = 0; n < 200 && !aborted; n++) begin
         @(negedge clk);
         if (per_rsp_valid) begin
            found = 1'b1;
            break;
         end
      end
      if (!found && !aborted) begin
         $display("Timed out waiting for the response with id %0d", id);
         aborted = 1'b1;
         errors++;
      end else if (found) begin
         assert (per_rsp.id == id) else begin
            $display("[FAIL] %0t per_rsp_o.id got %0d expected %0d", $time, per_rsp.id, id);
            errors++;
         end
         assert (per_rsp.opc == opc) else begin
            $display("[FAIL] %0t per_rsp_o.opc got %0d expected %0d", $time, per_rsp.opc, opc);
            errors++;
         end
         assert (per_rsp.rdata == data) else begin
            $display("[FAIL] %0t per_rsp_o.rdata got %h expected %h",
                     $time, per_rsp.rdata, data);
            errors++;
         end
      end
   endtask

   task automatic access(input logic [31:0] addr, input logic we, input logic [31:0] data,
                         input logic [3:0] be, input logic [3:0] id);
      bit g;
      logic [31:0] exp;
      if (!aborted) begin
         issue(addr, we, data, be, id, 100, g);
         exp = (we || addr[31]) ? 32'h0 : ref_mem[addr[9:2]];
         if (!g) begin
            $display("Request with id %0d was never granted", id);
            aborted = 1'b1;
            errors++;
         end else begin
            wait_rsp(id, addr[31], exp);
         end
      end
   endtask

   task automatic end_test(input int num, input string name);
      $display("Test %0d %s: %s (%0d errors)", num, name,
               (errors == test_start) ? "ok" : "errors", errors - test_start);
      test_start = errors;
   endtask

   initial begin
      bit g;
      void'($urandom(32'h3e24));
      for (int i = 0; i < 256; i++) begin
         ref_mem[i] = (32'h9e3779b9 * (i + 1)) ^ (i << 16);
      end
      clk = 1'b0;
      rst_n = 1'b0;
      hold = 1'b0;
      per_req_valid = 1'b0;
      per_req = '0;
      errors = 0;
      test_start = 0;
      payload_errors = 0;
      aborted = 1'b0;
      repeat (4) @(posedge clk);
      #2;
      rst_n = 1'b1;
      @(negedge clk);
      assert (!per_gnt && !aw_valid && !w_valid && !ar_valid && !per_rsp_valid && r_ready)
      else begin
         $display("Outputs were not idle after reset");
         errors++;
      end
      end_test(6, "idle after reset");

      access(32'h10, 1'b1, 32'hdeadbeef, 4'b0101, 4'd1);
      access(32'h10, 1'b0, 32'h0, 4'hf, 4'd2);
      access(32'h24, 1'b1, 32'h12345678, 4'hf, 4'd3);
      access(32'h24, 1'b0, 32'h0, 4'hf, 4'd4);
      end_test(1, "write then read");

      for (int i = 0; i < 12; i++) begin
         access({22'h0, 8'($urandom % 16), 2'b00}, 1'($urandom % 2), $urandom,
                4'($urandom), 4'(i));
      end
      end_test(2, "response ids");

      hold = 1'b1;
      issue(32'h100, 1'b1, 32'haaaa5555, 4'hf, 4'd3, 50, g);
      if (g) issue(32'h104, 1'b1, 32'h5555aaaa, 4'hf, 4'd4, 50, g);
      assert (g) else begin
         $display("A write was refused before the buffers were full");
         errors++;
      end
      issue(32'h108, 1'b1, 32'h0f0f0f0f, 4'hf, 4'd5, 8, g);
      assert (!g) else begin
         $display("A write was granted while the AW and W buffers were full");
         errors++;
      end
      access(32'h80, 1'b0, 32'h0, 4'hf, 4'd6);
      hold = 1'b0;
      wait_rsp(4'd3, 1'b0, 32'h0);
      wait_rsp(4'd4, 1'b0, 32'h0);
      access(32'h100, 1'b0, 32'h0, 4'hf, 4'd7);
      end_test(4, "back-pressure");

      access(32'h80000020, 1'b1, 32'h11111111, 4'hf, 4'd8);
      access(32'h80000040, 1'b0, 32'h0, 4'hf, 4'd9);
      access(32'h20, 1'b0, 32'h0, 4'hf, 4'd10);
      end_test(5, "error region");

      errors += payload_errors;
      end_test(3, "AW and W payloads");

      $display("Checks done with %0d errors", errors);
      if (errors == 0 && !aborted) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- tests/axi_mem_model.sv
`timescale 1ns/10ps
`default_nettype none

module axi_mem_model (
   input  wire                    clk_i,
   input  wire                    rst_n_i,
   input  wire                    hold_aw_w_i,  // Forces AW and W ready low.

   input  wire                    aw_valid_i,
   input  per2axi_pkg::aw_t       aw_i,
   output logic                   aw_ready_o,
   input  wire                    w_valid_i,
   input  per2axi_pkg::w_t        w_i,
   output logic                   w_ready_o,
   input  wire                    ar_valid_i,
   input  per2axi_pkg::ar_t       ar_i,
   output logic                   ar_ready_o,

   output logic                   b_valid_o,
   output per2axi_pkg::b_t        b_o,
   input  wire                    b_ready_i,
   output logic                   r_valid_o,
   output per2axi_pkg::r_t        r_o,
   input  wire                    r_ready_i
);

   logic [31:0]      mem [256];
   per2axi_pkg::aw_t aw_q;
   per2axi_pkg::w_t  w_q;
   logic             aw_held, w_held;
   logic             aw_fire, w_fire, ar_fire, b_fire, r_fire, b_busy;
   per2axi_pkg::ar_t ar_s;

   initial begin
      aw_ready_o = 1'b0;
      w_ready_o  = 1'b0;
      ar_ready_o = 1'b0;
      b_valid_o  = 1'b0;
      r_valid_o  = 1'b0;
      b_o        = '0;
      r_o        = '0;
      for (int i = 0; i < 256; i++) begin
         mem[i] = (32'h9e3779b9 * (i + 1)) ^ (i << 16); // Differs for every word.
      end
   end

   always @(posedge clk_i) begin
      aw_fire = aw_valid_i && aw_ready_o;
      w_fire  = w_valid_i && w_ready_o;
      ar_fire = ar_valid_i && ar_ready_o;
      b_fire  = b_valid_o && b_ready_i;
      r_fire  = r_valid_o && r_ready_i;
      b_busy  = b_valid_o;
      ar_s    = ar_i;
      if (aw_fire) aw_q = aw_i;
      if (w_fire) w_q = w_i;
      #2;
      if (!rst_n_i) begin
         aw_held = 1'b0;
         w_held  = 1'b0;
         b_valid_o = 1'b0;
         r_valid_o = 1'b0;
         b_o = '0;
         r_o = '0;
      end else begin
         if (b_fire) b_valid_o = 1'b0;
         if (r_fire) r_valid_o = 1'b0;
         if (aw_fire) aw_held = 1'b1;
         if (w_fire) w_held = 1'b1;
         if (aw_held && w_held && !b_busy) begin   // Pair AW with W.
            b_o = '0;
            b_o.id = aw_q.id;
            if (aw_q.addr[31]) begin
               b_o.resp = per2axi_pkg::SLVERR;
            end else begin
               for (int b = 0; b < 4; b++) begin
                  if (w_q.strb[b]) mem[aw_q.addr[9:2]][8*b +: 8] = w_q.data[8*b +: 8];
               end
               b_o.resp = per2axi_pkg::OKAY;
            end
            b_valid_o = 1'b1;
            aw_held = 1'b0;
            w_held  = 1'b0;
         end
         if (ar_fire) begin
            r_o = '0;
            r_o.id = ar_s.id;
            r_o.last = 1'b1;
            r_o.resp = ar_s.addr[31] ? per2axi_pkg::SLVERR : per2axi_pkg::OKAY;
            r_o.data = ar_s.addr[31] ? 32'h0 : mem[ar_s.addr[9:2]];
            r_valid_o = 1'b1;
         end
      end
      aw_ready_o = rst_n_i && !hold_aw_w_i && !aw_held && ($urandom % 4 != 0);
      w_ready_o  = rst_n_i && !hold_aw_w_i && !w_held && ($urandom % 4 != 0);
      ar_ready_o = rst_n_i && !r_valid_o && ($urandom % 3 != 0);
   end

endmodule

`default_nettype wire

//--- source/per2axi.sv
`timescale 1ns/10ps
`default_nettype none

`include "per2axi_defs.svh"

module per2axi (
   input  wire                    clk_i,
   input  wire                    rst_n_i,

   input  wire                    per_req_valid_i,
   input  per2axi_pkg::per_req_t  per_req_i,
   output logic                   per_gnt_o,
   output logic                   per_rsp_valid_o,
   output per2axi_pkg::per_rsp_t  per_rsp_o,

   output logic                   aw_valid_o,
   output per2axi_pkg::aw_t       aw_o,
   input  wire                    aw_ready_i,

   output logic                   w_valid_o,
   output per2axi_pkg::w_t        w_o,
   input  wire                    w_ready_i,

   output logic                   ar_valid_o,
   output per2axi_pkg::ar_t       ar_o,
   input  wire                    ar_ready_i,

   input  wire                    b_valid_i,
   input  per2axi_pkg::b_t        b_i,
   output logic                   b_ready_o,

   input  wire                    r_valid_i,
   input  per2axi_pkg::r_t        r_i,
   output logic                   r_ready_o
);

   // Request channel to buffer inputs.
   per2axi_pkg::aw_t aw_in;
   per2axi_pkg::w_t  w_in;
   per2axi_pkg::ar_t ar_in;
   logic             aw_in_valid;
   logic             aw_in_ready;
   logic             w_in_valid;
   logic             w_in_ready;
   logic             ar_in_valid;
   logic             ar_in_ready;

   per2axi_req_channel req_channel_i (
      .per_req_valid_i (per_req_valid_i),
      .per_req_i       (per_req_i),
      .per_gnt_o       (per_gnt_o),
      .aw_valid_o      (aw_in_valid),
      .aw_o            (aw_in),
      .aw_ready_i      (aw_in_ready),
      .w_valid_o       (w_in_valid),
      .w_o             (w_in),
      .w_ready_i       (w_in_ready),
      .ar_valid_o      (ar_in_valid),
      .ar_o            (ar_in),
      .ar_ready_i      (ar_in_ready)
   );

   per2axi_buffer #(
      .DEPTH     (`PER2AXI_BUFFER_DEPTH),
      .payload_t (per2axi_pkg::aw_t)
   ) aw_buffer_i (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .valid_i (aw_in_valid),
      .data_i  (aw_in),
      .ready_o (aw_in_ready),
      .valid_o (aw_valid_o),
      .data_o  (aw_o),
      .ready_i (aw_ready_i)
   );

   per2axi_buffer #(
      .DEPTH     (`PER2AXI_BUFFER_DEPTH),
      .payload_t (per2axi_pkg::w_t)
   ) w_buffer_i (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .valid_i (w_in_valid),
      .data_i  (w_in),
      .ready_o (w_in_ready),
      .valid_o (w_valid_o),
      .data_o  (w_o),
      .ready_i (w_ready_i)
   );

   per2axi_buffer #(
      .DEPTH     (`PER2AXI_BUFFER_DEPTH),
      .payload_t (per2axi_pkg::ar_t)
   ) ar_buffer_i (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .valid_i (ar_in_valid),
      .data_i  (ar_in),
      .ready_o (ar_in_ready),
      .valid_o (ar_valid_o),
      .data_o  (ar_o),
      .ready_i (ar_ready_i)
   );

   per2axi_res_channel res_channel_i (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .b_valid_i       (b_valid_i),
      .b_i             (b_i),
      .b_ready_o       (b_ready_o),
      .r_valid_i       (r_valid_i),
      .r_i             (r_i),
      .r_ready_o       (r_ready_o),
      .per_rsp_valid_o (per_rsp_valid_o),
      .per_rsp_o       (per_rsp_o)
   );

endmodule

`default_nettype wire

//--- source/per2axi_res_channel.sv
`timescale 1ns/10ps
`default_nettype none

module per2axi_res_channel (
   input  wire                    clk_i,
   input  wire                    rst_n_i,

   input  wire                    b_valid_i,
   input  per2axi_pkg::b_t        b_i,
   output logic                   b_ready_o,

   input  wire                    r_valid_i,
   input  per2axi_pkg::r_t        r_i,
   output logic                   r_ready_o,

   output logic                   per_rsp_valid_o,
   output per2axi_pkg::per_rsp_t  per_rsp_o
);

   logic b_fire;
   logic r_fire;

   // The peripheral side cannot stall, so R is always taken.
   assign r_ready_o = 1'b1;
   assign b_ready_o = !r_valid_i; // R wins.

   assign r_fire = r_valid_i && r_ready_o;
   assign b_fire = b_valid_i && b_ready_o;

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         per_rsp_valid_o <= 1'b0;
      end else begin
         per_rsp_valid_o <= r_fire || b_fire; // One cycle pulse.
      end
   end

   always_ff @(posedge clk_i) begin
      if (r_fire) begin
         per_rsp_o.rdata <= r_i.data;
         per_rsp_o.opc   <= r_i.resp[1];   // SLVERR or DECERR.
         per_rsp_o.id    <= r_i.id;
      end else if (b_fire) begin
         per_rsp_o.rdata <= '0;
         per_rsp_o.opc   <= b_i.resp[1];
         per_rsp_o.id    <= b_i.id;
      end
   end

endmodule

`default_nettype wire

//--- source/per2axi_req_channel.sv
`timescale 1ns/10ps
`default_nettype none

`include "per2axi_defs.svh"

module per2axi_req_channel (
   input  wire                    per_req_valid_i,
   input  per2axi_pkg::per_req_t  per_req_i,
   output logic                   per_gnt_o,

   output logic                   aw_valid_o,
   output per2axi_pkg::aw_t       aw_o,
   input  wire                    aw_ready_i,

   output logic                   w_valid_o,
   output per2axi_pkg::w_t        w_o,
   input  wire                    w_ready_i,

   output logic                   ar_valid_o,
   output per2axi_pkg::ar_t       ar_o,
   input  wire                    ar_ready_i
);

   localparam int unsigned BYTES    = `PER2AXI_DATA_WIDTH / 8;
   localparam int unsigned BYTE_OFF = $clog2(BYTES);

   localparam logic [1:0] BURST_INCR   = 2'b01;
   localparam logic [2:0] PROT_DEFAULT = 3'b000; // Unprivileged, secure, data.
   localparam logic [3:0] CACHE_DEFAULT = 4'b0000;
   localparam logic [3:0] QOS_DEFAULT  = 4'b0000;
   localparam logic [3:0] REGION_DEFAULT = 4'b0000;
   localparam logic [`PER2AXI_USER_WIDTH-1:0] USER_DEFAULT = '0;

   per2axi_pkg::aw_t addr_chan;
   logic             write_gnt;
   logic             read_gnt;

   // A write needs room in both AW and W, a read only in AR.
   assign write_gnt = per_req_valid_i && per_req_i.we && aw_ready_i && w_ready_i;
   assign read_gnt  = per_req_valid_i && !per_req_i.we && ar_ready_i;

   assign per_gnt_o  = write_gnt || read_gnt;
   assign aw_valid_o = write_gnt;
   assign w_valid_o  = write_gnt;
   assign ar_valid_o = read_gnt;

   always_comb begin
      addr_chan        = '0;
      addr_chan.addr   = {per_req_i.addr[`PER2AXI_ADDR_WIDTH-1:BYTE_OFF],
                          {BYTE_OFF{1'b0}}}; // Word aligned.
      addr_chan.prot   = PROT_DEFAULT;
      addr_chan.region = REGION_DEFAULT;
      addr_chan.len    = 8'd0;               // Single beat.
      addr_chan.size   = 3'(BYTE_OFF);
      addr_chan.burst  = BURST_INCR;
      addr_chan.lock   = 1'b0;
      addr_chan.cache  = CACHE_DEFAULT;
      addr_chan.qos    = QOS_DEFAULT;
      addr_chan.id     = per_req_i.id;
      addr_chan.user   = USER_DEFAULT;
   end

   // AW and AR share one layout.
   assign aw_o = addr_chan;
   assign ar_o = addr_chan;

   always_comb begin
      w_o      = '0;
      w_o.data = per_req_i.wdata;
      w_o.strb = per_req_i.be;
      w_o.last = 1'b1;
      w_o.user = USER_DEFAULT;
   end

endmodule

`default_nettype wire

//--- source/per2axi_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module per2axi_buffer #(
   parameter int unsigned DEPTH = 2,
   parameter type payload_t = logic [31:0]
) (
   input  wire      clk_i,
   input  wire      rst_n_i,

   input  wire      valid_i,
   input  payload_t data_i,
   output logic     ready_o,

   output logic     valid_o,
   output payload_t data_o,
   input  wire      ready_i
);

   localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int unsigned CNT_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
   localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(DEPTH);

   payload_t         mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             push;
   logic             pop;

   assign full    = (count == FULL_CNT);
   assign valid_o = (count != '0);
   assign data_o  = mem[rd_ptr];

   // A full buffer still accepts while it drains in the same cycle.
   assign ready_o = !full || ready_i;

   assign push = valid_i && ready_o;
   assign pop  = valid_o && ready_i;

   always_ff @(posedge clk_i) begin
      if (push) begin
         mem[wr_ptr] <= data_i;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1; // Wrap.
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
         end
         if (push && !pop) begin
            count <= count + 1'b1;
         end else if (pop && !push) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/per2axi_pkg.sv
`default_nettype none

`include "per2axi_defs.svh"

package per2axi_pkg;

   typedef enum logic [1:0] {
      OKAY   = 2'b00,
      EXOKAY = 2'b01,
      SLVERR = 2'b10,
      DECERR = 2'b11
   } axi_resp_e;

   typedef struct packed {
      logic [`PER2AXI_ADDR_WIDTH-1:0]   addr;
      logic                             we;    // High for a write.
      logic [`PER2AXI_DATA_WIDTH-1:0]   wdata;
      logic [`PER2AXI_DATA_WIDTH/8-1:0] be;    // Byte enables.
      logic [`PER2AXI_ID_WIDTH-1:0]     id;
   } per_req_t;

   typedef struct packed {
      logic [`PER2AXI_DATA_WIDTH-1:0] rdata;
      logic                           opc;   // Error flag.
      logic [`PER2AXI_ID_WIDTH-1:0]   id;
   } per_rsp_t;

   typedef struct packed {
      logic [`PER2AXI_ADDR_WIDTH-1:0] addr;
      logic [2:0]                     prot;
      logic [3:0]                     region;
      logic [7:0]                     len;
      logic [2:0]                     size;
      logic [1:0]                     burst;
      logic                           lock;
      logic [3:0]                     cache;
      logic [3:0]                     qos;
      logic [`PER2AXI_ID_WIDTH-1:0]   id;
      logic [`PER2AXI_USER_WIDTH-1:0] user;
   } aw_t;

   // AR carries exactly the AW fields.
   typedef aw_t ar_t;

   typedef struct packed {
      logic [`PER2AXI_DATA_WIDTH-1:0]   data;
      logic [`PER2AXI_DATA_WIDTH/8-1:0] strb;
      logic                             last;
      logic [`PER2AXI_USER_WIDTH-1:0]   user;
   } w_t;

   typedef struct packed {
      axi_resp_e                      resp;
      logic [`PER2AXI_ID_WIDTH-1:0]   id;
      logic [`PER2AXI_USER_WIDTH-1:0] user;
   } b_t;

   typedef struct packed {
      logic [`PER2AXI_DATA_WIDTH-1:0] data;
      axi_resp_e                      resp;
      logic                           last;
      logic [`PER2AXI_ID_WIDTH-1:0]   id;
      logic [`PER2AXI_USER_WIDTH-1:0] user;
   } r_t;

endpackage

`default_nettype wire

//--- source/per2axi_defs.svh
`ifndef PER2AXI_DEFS_SVH
`define PER2AXI_DEFS_SVH

// Address bus width.
`define PER2AXI_ADDR_WIDTH 32

// Data bus width; one peripheral word per AXI beat.
`define PER2AXI_DATA_WIDTH 32

// Transaction id width.
`define PER2AXI_ID_WIDTH 4

// AXI user field width, passed through unchanged.
`define PER2AXI_USER_WIDTH 6

// Entries held by each channel buffer.
`define PER2AXI_BUFFER_DEPTH 2

`endif
